/* design/tap_ctrl_if.sv */
`timescale 1ns/1ps

// Decoded TAP state strobes, one bit per state of interest
interface tap_ctrl_if;

  logic capture_dr;
  logic shift_dr;
  logic update_dr;
  logic capture_ir;
  logic shift_ir;
  logic update_ir;
  // Forced reset from the TMS history, valid in the current cycle
  logic tms_reset;

  // State machine side
  modport fsm_mp (
    output capture_dr, shift_dr, update_dr,
    output capture_ir, shift_ir, update_ir,
    output tms_reset
  );

  // Register side
  modport reg_mp (
    input capture_dr, shift_dr, update_dr,
    input capture_ir, shift_ir, update_ir,
    input tms_reset
  );

endinterface

/* design/tap_data_regs.sv */
`timescale 1ns/1ps

module tap_data_regs #(
  parameter int unsigned num_chains_p = 5
) (
  input  logic                     tck_i,
  input  logic                     rst_ni,
  input  logic                     td_i,
  tap_ctrl_if.reg_mp               ctrl_i,
  input  tap_instr_pkg::instr_t    instr_i,
  input  logic                     ir_tdo_i,
  input  logic [num_chains_p-1:0]  scan_out_i,
  output logic                     td_o
);

  tap_instr_pkg::idcode_t idcode_q;
  logic                   idcode_sel;
  logic                   bypass_q;
  logic                   dr_tdo;
  logic                   tdo_d;

  assign idcode_sel = (instr_i == tap_instr_pkg::instr_idcode);

  // IDCODE register
  // Reloads only in capture_dr and shifts right toward TDO
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      idcode_q <= tap_instr_pkg::idcode_value;
    else if (idcode_sel && ctrl_i.capture_dr)
      idcode_q <= tap_instr_pkg::idcode_value;
    else if (idcode_sel && ctrl_i.shift_dr)
      idcode_q <= {td_i, idcode_q[31:1]};
  end

  // One-bit bypass loads on any DR shift
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bypass_q <= 1'b0;
    else if (ctrl_i.shift_dr)
      bypass_q <= td_i;
  end

  // Data register source
  // Codes outside the chain range fall back to bypass
  always_comb
  begin
    dr_tdo = bypass_q;
    if (idcode_sel)
      dr_tdo = idcode_q[0];
    else
    begin
      for (int k = 0; k < num_chains_p; k++)
      begin
        if (instr_i == tap_instr_pkg::instr_t'(tap_instr_pkg::instr_chain_base + k))
          dr_tdo = scan_out_i[k];
      end
    end
  end

  // IR scan takes priority over any data register
  assign tdo_d = ctrl_i.shift_ir ? ir_tdo_i : dr_tdo;

  // Output stage on the falling edge
  // State and instruction are taken as they stand at this edge
  // The bit is then stable half a cycle before the next rising edge
  always_ff @(negedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      td_o <= 1'b0;
    else
      td_o <= tdo_d;
  end

endmodule

/* design/tap_fsm.sv */
`timescale 1ns/1ps

module tap_fsm (
  input  logic        tck_i,
  input  logic        rst_ni,
  input  logic        tms_i,
  tap_ctrl_if.fsm_mp  ctrl_o
);

  // TMS history holds the previous len-1 samples
  localparam int unsigned hist_len = tap_state_pkg::tms_reset_len - 1;

  tap_state_pkg::tap_state_t state_q;
  tap_state_pkg::tap_state_t state_d;
  logic [hist_len-1:0]       tms_hist_q;
  logic                      tms_reset;

  // Shift register of past TMS values, newest at bit 0
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      tms_hist_q <= '0;
    else
      tms_hist_q <= {tms_hist_q[hist_len-2:0], tms_i};
  end

  // All history bits plus the current TMS high
  assign tms_reset = &{tms_hist_q, tms_i};

  // Standard TMS transition table
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      tap_state_pkg::test_logic_reset:
        state_d = tms_i ? tap_state_pkg::test_logic_reset : tap_state_pkg::run_test_idle;
      tap_state_pkg::run_test_idle:
        state_d = tms_i ? tap_state_pkg::select_dr : tap_state_pkg::run_test_idle;
      tap_state_pkg::select_dr:
        state_d = tms_i ? tap_state_pkg::select_ir : tap_state_pkg::capture_dr;
      tap_state_pkg::capture_dr, tap_state_pkg::shift_dr:
        state_d = tms_i ? tap_state_pkg::exit1_dr : tap_state_pkg::shift_dr;
      tap_state_pkg::exit1_dr:
        state_d = tms_i ? tap_state_pkg::update_dr : tap_state_pkg::pause_dr;
      tap_state_pkg::pause_dr:
        state_d = tms_i ? tap_state_pkg::exit2_dr : tap_state_pkg::pause_dr;
      tap_state_pkg::exit2_dr:
        state_d = tms_i ? tap_state_pkg::update_dr : tap_state_pkg::shift_dr;
      tap_state_pkg::select_ir:
        state_d = tms_i ? tap_state_pkg::test_logic_reset : tap_state_pkg::capture_ir;
      tap_state_pkg::capture_ir, tap_state_pkg::shift_ir:
        state_d = tms_i ? tap_state_pkg::exit1_ir : tap_state_pkg::shift_ir;
      tap_state_pkg::exit1_ir:
        state_d = tms_i ? tap_state_pkg::update_ir : tap_state_pkg::pause_ir;
      tap_state_pkg::pause_ir:
        state_d = tms_i ? tap_state_pkg::exit2_ir : tap_state_pkg::pause_ir;
      tap_state_pkg::exit2_ir:
        state_d = tms_i ? tap_state_pkg::update_ir : tap_state_pkg::shift_ir;
      // Both update states share the same exits
      default:
        state_d = tms_i ? tap_state_pkg::select_dr : tap_state_pkg::run_test_idle;
    endcase
    // Forced reset wins over the table
    if (tms_reset)
      state_d = tap_state_pkg::test_logic_reset;
  end

  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= tap_state_pkg::test_logic_reset;
    else
      state_q <= state_d;
  end

  // State decode onto the shared strobes
  assign ctrl_o.capture_dr = (state_q == tap_state_pkg::capture_dr);
  assign ctrl_o.shift_dr   = (state_q == tap_state_pkg::shift_dr);
  assign ctrl_o.update_dr  = (state_q == tap_state_pkg::update_dr);
  assign ctrl_o.capture_ir = (state_q == tap_state_pkg::capture_ir);
  assign ctrl_o.shift_ir   = (state_q == tap_state_pkg::shift_ir);
  assign ctrl_o.update_ir  = (state_q == tap_state_pkg::update_ir);
  assign ctrl_o.tms_reset  = tms_reset;

endmodule

/* design/tap_instr_pkg.sv */
package tap_instr_pkg;

  // Instruction register width
  localparam int unsigned ir_width = 5;

  // One instruction code
  typedef logic [ir_width-1:0] instr_t;

  // Active after reset and after a forced TMS reset
  localparam instr_t instr_idcode = 5'b00010;

  // Code of scan chain 0
  // Chain k sits at this code plus k
  localparam instr_t instr_chain_base = 5'b00100;

  // All ones selects the one-bit bypass register
  localparam instr_t instr_bypass = 5'b11111;

  // Fixed value loaded in capture_ir
  // Low two bits 01 let a board test spot a broken scan path
  localparam instr_t ir_capture_pattern = 5'b00101;

  // Device identification register
  typedef logic [31:0] idcode_t;

  // Version 1, part 0x0005, manufacturer 0x521
  // LSB must be one per the standard
  localparam idcode_t idcode_value = 32'h1000_5A43;

endpackage

/* design/tap_instr_reg.sv */
`timescale 1ns/1ps

module tap_instr_reg #(
  parameter int unsigned num_chains_p = 5
) (
  input  logic                      tck_i,
  input  logic                      rst_ni,
  input  logic                      td_i,
  tap_ctrl_if.reg_mp                ctrl_i,
  output tap_instr_pkg::instr_t     instr_o,
  output logic                      ir_tdo_o,
  output logic [num_chains_p-1:0]   scan_sel_o
);

  // Shift stage and the instruction currently in effect
  tap_instr_pkg::instr_t ir_shift_q;
  tap_instr_pkg::instr_t instr_q;

  // Capture loads the fixed pattern
  // Shift brings TDI in at the MSB, LSB leaves toward TDO
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ir_shift_q <= '0;
    else if (ctrl_i.capture_ir)
      ir_shift_q <= tap_instr_pkg::ir_capture_pattern;
    else if (ctrl_i.shift_ir)
      ir_shift_q <= {td_i, ir_shift_q[tap_instr_pkg::ir_width-1:1]};
  end

  assign ir_tdo_o = ir_shift_q[0];

  // Active instruction
  // Reset and the five-TMS reset both fall back to IDCODE
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
      instr_q <= tap_instr_pkg::instr_idcode;
    else if (ctrl_i.tms_reset)
      instr_q <= tap_instr_pkg::instr_idcode;
    else if (ctrl_i.update_ir)
      instr_q <= ir_shift_q;
  end

  assign instr_o = instr_q;

  // One-hot chain selects
  // Chain k answers to base code plus k, nothing else drives a select
  for (genvar k = 0; k < num_chains_p; k++)
  begin : g_sel
    localparam tap_instr_pkg::instr_t chain_code =
      tap_instr_pkg::instr_t'(tap_instr_pkg::instr_chain_base + k);

    assign scan_sel_o[k] = (instr_q == chain_code);
  end

endmodule

/* design/tap_state_pkg.sv */
package tap_state_pkg;

  // Sixteen TAP controller states
  // Order follows the standard state diagram, DR column then IR column
  typedef enum logic [3:0] {
    test_logic_reset,
    run_test_idle,
    select_dr,
    capture_dr,
    shift_dr,
    exit1_dr,
    pause_dr,
    exit2_dr,
    update_dr,
    select_ir,
    capture_ir,
    shift_ir,
    exit1_ir,
    pause_ir,
    exit2_ir,
    update_ir
  } tap_state_t;

  // Consecutive TMS-high cycles that force test_logic_reset
  // Five is the worst case path length back to reset
  localparam int unsigned tms_reset_len = 5;

endpackage

/* design/tap_top.sv */
`timescale 1ns/1ps

module tap_top #(
  parameter int unsigned num_chains_p = 5
) (
  input  logic                     tck_i,
  input  logic                     rst_ni,
  input  logic                     tms_i,
  input  logic                     td_i,
  output logic                     td_o,
  output logic                     shift_dr_o,
  output logic                     capture_dr_o,
  output logic                     update_dr_o,
  output logic                     scan_in_o,
  output logic [num_chains_p-1:0]  scan_sel_o,
  input  logic [num_chains_p-1:0]  scan_out_i
);

  // State strobes shared by the FSM and both register blocks
  tap_ctrl_if ctrl ();

  tap_instr_pkg::instr_t instr;
  logic                  ir_tdo;

  tap_fsm u_fsm (
    .tck_i  (tck_i),
    .rst_ni (rst_ni),
    .tms_i  (tms_i),
    .ctrl_o (ctrl)
  );

  tap_instr_reg #(
    .num_chains_p (num_chains_p)
  ) u_instr_reg (
    .tck_i      (tck_i),
    .rst_ni     (rst_ni),
    .td_i       (td_i),
    .ctrl_i     (ctrl),
    .instr_o    (instr),
    .ir_tdo_o   (ir_tdo),
    .scan_sel_o (scan_sel_o)
  );

  tap_data_regs #(
    .num_chains_p (num_chains_p)
  ) u_data_regs (
    .tck_i      (tck_i),
    .rst_ni     (rst_ni),
    .td_i       (td_i),
    .ctrl_i     (ctrl),
    .instr_i    (instr),
    .ir_tdo_i   (ir_tdo),
    .scan_out_i (scan_out_i),
    .td_o       (td_o)
  );

  // External chains see TDI directly and the raw DR strobes
  assign scan_in_o    = td_i;
  assign shift_dr_o   = ctrl.shift_dr;
  assign capture_dr_o = ctrl.capture_dr;
  assign update_dr_o  = ctrl.update_dr;

endmodule

/* run.sh */
#!/bin/sh
# Build and run the TAP controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f verilog.f --top-module tap_tb -o tap_sim
sim_out=$(./obj_dir/tap_sim)
echo "$sim_out"
if echo "$sim_out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1

/* verification/tap_checker.sv */
`timescale 1ns/1ps

// Reference TAP model, compared against the DUT at every rising TCK edge
module tap_checker #(
  parameter int unsigned num_chains_p = 5
) (
  input  logic                    tck_i,
  input  logic                    rst_ni,
  input  logic                    tms_i,
  input  logic                    tdi_i,
  input  logic                    tdo_i,
  input  logic                    shift_dr_i,
  input  logic                    capture_dr_i,
  input  logic                    update_dr_i,
  input  logic                    scan_in_i,
  input  logic [num_chains_p-1:0] scan_sel_i,
  input  logic [num_chains_p-1:0] scan_out_i,
  output int                      err_cnt_o
);

  // Next state for TMS low and TMS high, indexed in enum order
  // TLR RTI SDR CDR SHDR E1DR PDR E2DR / UDR SIR CIR SHIR E1IR PIR E2IR UIR
  localparam logic [3:0] next_low [16] = '{4'd1, 4'd1, 4'd3, 4'd4, 4'd4, 4'd6, 4'd6, 4'd4,
                                           4'd1, 4'd10, 4'd11, 4'd11, 4'd13, 4'd13, 4'd11, 4'd1};
  localparam logic [3:0] next_high [16] = '{4'd0, 4'd2, 4'd9, 4'd5, 4'd5, 4'd8, 4'd7, 4'd8,
                                            4'd2, 4'd0, 4'd12, 4'd12, 4'd15, 4'd14, 4'd15, 4'd2};

  // Model registers, starting from their reset values
  tap_state_pkg::tap_state_t               state_m  = tap_state_pkg::test_logic_reset;
  logic [tap_state_pkg::tms_reset_len-2:0] hist_m   = '0;
  tap_instr_pkg::instr_t                   ir_m     = '0;
  tap_instr_pkg::instr_t                   instr_m  = tap_instr_pkg::instr_idcode;
  tap_instr_pkg::idcode_t                  idcode_m = tap_instr_pkg::idcode_value;
  logic                                    bypass_m = 1'b0;
  logic                                    force_m;
  logic                                    tdo_m;
  logic [num_chains_p-1:0]                 sel_m;
  int                                      errors   = 0;

  assign err_cnt_o = errors;

  task automatic compare(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH at %0d ns: %s is %0h, model expects %0h", $time, what, got, exp);
    end
  endtask

  always @(posedge tck_i)
  begin
    if (rst_ni)
    begin
      // Chain k answers to the base code plus k
      for (int k = 0; k < num_chains_p; k++)
        sel_m[k] = (instr_m == tap_instr_pkg::instr_t'(tap_instr_pkg::instr_chain_base + k));
      // Unknown codes land on bypass
      tdo_m = bypass_m;
      if (state_m == tap_state_pkg::shift_ir)
        tdo_m = ir_m[0];
      else if (instr_m == tap_instr_pkg::instr_idcode)
        tdo_m = idcode_m[0];
      else if (|sel_m)
        tdo_m = |(sel_m & scan_out_i);
      compare(8'({shift_dr_i, capture_dr_i, update_dr_i}),
              8'({state_m == tap_state_pkg::shift_dr, state_m == tap_state_pkg::capture_dr,
                  state_m == tap_state_pkg::update_dr}), "shift/capture/update_dr_o");
      compare(8'(scan_sel_i), 8'(sel_m), "scan_sel_o");
      compare(8'(scan_in_i), 8'(tdi_i), "scan_in_o");
      compare(8'(tdo_i), 8'(tdo_m), "td_o");

      // Advance the model by one edge, IDCODE select taken before any IR update
      force_m = &{hist_m, tms_i};
      if (instr_m == tap_instr_pkg::instr_idcode && state_m == tap_state_pkg::capture_dr)
        idcode_m = tap_instr_pkg::idcode_value;
      else if (instr_m == tap_instr_pkg::instr_idcode && state_m == tap_state_pkg::shift_dr)
        idcode_m = {tdi_i, idcode_m[31:1]};
      if (state_m == tap_state_pkg::shift_dr)
        bypass_m = tdi_i;
      if (force_m)
        instr_m = tap_instr_pkg::instr_idcode;
      else if (state_m == tap_state_pkg::update_ir)
        instr_m = ir_m;
      if (state_m == tap_state_pkg::capture_ir)
        ir_m = tap_instr_pkg::ir_capture_pattern;
      else if (state_m == tap_state_pkg::shift_ir)
        ir_m = {tdi_i, ir_m[tap_instr_pkg::ir_width-1:1]};
      hist_m = {hist_m[tap_state_pkg::tms_reset_len-3:0], tms_i};
      if (force_m)
        state_m = tap_state_pkg::test_logic_reset;
      else
        state_m = tap_state_pkg::tap_state_t'(tms_i ? next_high[state_m] : next_low[state_m]);
    end
  end

endmodule

/* verification/tap_tb.sv */
`timescale 1ns/1ps

module tap_tb;

  localparam int num_chains = 5;
  localparam int chain_len  = 8;
  // Reset, then rough edge counts of tests one to six
  localparam int run_cycles = 10 + 40 + 22 + 76 + 140 + 62 + 2001;

  logic                  tck = 1'b0;
  logic                  rst_n, tms, tdi, tdo, shift_dr, capture_dr, update_dr, scan_in;
  logic [num_chains-1:0] scan_sel, scan_out;
  logic [chain_len-1:0]  chain_q [num_chains];
  logic [chain_len-1:0]  chain_init [num_chains];
  int                    seed = 8;
  int                    errors;
  int                    last_errors = 0;
  int                    tests_passed = 0;
  int                    tests_failed = 0;

  always #4 tck = ~tck;

  tap_top #(.num_chains_p(num_chains)) dut0 (
    .tck_i(tck), .rst_ni(rst_n), .tms_i(tms), .td_i(tdi), .td_o(tdo),
    .shift_dr_o(shift_dr), .capture_dr_o(capture_dr), .update_dr_o(update_dr),
    .scan_in_o(scan_in), .scan_sel_o(scan_sel), .scan_out_i(scan_out)
  );

  tap_checker #(.num_chains_p(num_chains)) chk0 (
    .tck_i(tck), .rst_ni(rst_n), .tms_i(tms), .tdi_i(tdi), .tdo_i(tdo),
    .shift_dr_i(shift_dr), .capture_dr_i(capture_dr), .update_dr_i(update_dr),
    .scan_in_i(scan_in), .scan_sel_i(scan_sel), .scan_out_i(scan_out), .err_cnt_o(errors)
  );

  // Chain stubs, preloaded during reset, shift toward the LSB
  always @(posedge tck)
  begin
    for (int k = 0; k < num_chains; k++)
    begin
      if (!rst_n)
        chain_q[k] <= chain_init[k];
      else if (scan_sel[k] && shift_dr)
        chain_q[k] <= {scan_in, chain_q[k][chain_len-1:1]};
    end
  end

  always_comb
  begin
    for (int k = 0; k < num_chains; k++)
      scan_out[k] = rst_n ? chain_q[k][0] : chain_init[k][0];
  end

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // New TMS and TDI shortly after the rising edge
  task automatic drive(input logic tms_v, input logic tdi_v);
    @(posedge tck);
    #1;
    tms = tms_v;
    tdi = tdi_v;
  endtask

  // Idle to shift_ir, random prefix then code LSB first, back to idle
  task automatic scan_ir(input tap_instr_pkg::instr_t code, input int extra);
    drive(1'b1, 1'b0);
    drive(1'b1, 1'b0);
    drive(1'b0, 1'b0);
    drive(1'b0, 1'b0);
    for (int i = 0; i < extra + 5; i++)
      drive(i == extra + 4, (i < extra) ? rand_bit() : code[i-extra]);
    drive(1'b1, 1'b0);
    drive(1'b0, 1'b0);
  endtask

  // Idle to shift_dr, n random bits, back to idle
  task automatic scan_dr(input int n);
    drive(1'b1, 1'b0);
    drive(1'b0, 1'b0);
    drive(1'b0, 1'b0);
    for (int i = 0; i < n; i++)
      drive(i == n - 1, rand_bit());
    drive(1'b1, 1'b0);
    drive(1'b0, 1'b0);
  endtask

  // One more edge so the checker sees the last drive
  task automatic finish_test(input string name);
    @(posedge tck);
    #2;
    if (errors == last_errors)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errors - last_errors);
    end
    last_errors = errors;
  endtask

  initial
  begin
    tap_instr_pkg::instr_t code;
    int                    offs;
    tms = 1'b1;
    tdi = 1'b0;
    rst_n = 1'b0;
    for (int k = 0; k < num_chains; k++)
      chain_init[k] = chain_len'($random(seed));
    repeat (10) @(posedge tck);
    #1;
    rst_n = 1'b1;
    drive(1'b0, 1'b0);
    scan_dr(32);
    finish_test("idcode after reset");
    scan_ir(tap_instr_pkg::instr_idcode, 10);
    finish_test("ir capture pattern");
    scan_ir(tap_instr_pkg::instr_bypass, 0);
    scan_dr(20);
    // Any code that is neither IDCODE nor a chain
    do
    begin
      code = tap_instr_pkg::instr_t'($random(seed));
      offs = int'(code) - int'(tap_instr_pkg::instr_chain_base);
    end
    while (code == tap_instr_pkg::instr_idcode || (offs >= 0 && offs < num_chains));
    scan_ir(code, 0);
    scan_dr(20);
    finish_test("bypass");
    for (int k = 0; k < num_chains; k++)
    begin
      scan_ir(tap_instr_pkg::instr_t'(tap_instr_pkg::instr_chain_base + k), 0);
      scan_dr(chain_len + 4);
    end
    finish_test("scan chains");
    scan_ir(tap_instr_pkg::instr_t'(tap_instr_pkg::instr_chain_base + 2), 0);
    repeat (7)
      drive(rand_bit(), rand_bit());
    repeat (tap_state_pkg::tms_reset_len)
      drive(1'b1, rand_bit());
    drive(1'b0, 1'b0);
    scan_dr(32);
    finish_test("forced tms reset");
    repeat (2000)
      drive(rand_bit(), rand_bit());
    finish_test("random tms and tdi");
    $display("tests passed %0d, tests failed %0d, mismatches %0d",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  // Watchdog for a stuck run
  initial
  begin
    #((run_cycles + 200) * 8);
    $display("watchdog expired before all tests finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* verilog.f */
design/tap_state_pkg.sv
design/tap_instr_pkg.sv
design/tap_ctrl_if.sv
design/tap_fsm.sv
design/tap_instr_reg.sv
design/tap_data_regs.sv
design/tap_top.sv
verification/tap_checker.sv
verification/tap_tb.sv
